//--- src.f
rtl/mips_pkg.sv
rtl/cp0_pkg.sv
rtl/exc_decode.sv
rtl/pipe_control.sv
rtl/cp0_regs.sv
rtl/exc_unit_top.sv
tb/exc_unit_sva.sv
tb/tb_exc_unit.sv

//--- tb/tb_exc_unit.sv
//----------------------------------------
// Exception unit testbench
// Random stimulus checked every cycle against
// a CP0 and pipeline control model
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_exc_unit;

    localparam bit BOOT_BEV = 1'b1;
    localparam int N_TABLE  = 300;
    localparam int N_SYNC   = 10;
    localparam int N_INT    = 8;
    localparam int N_ERET   = 10;
    localparam int N_APB    = 100;

    // Cycle budget summed over the tests
    localparam int TEST_CYCLES = 10 + 15 + (N_TABLE + 1) + 2 * (3 + N_SYNC * 10)
                               + 4 * (3 + N_INT * 7) + N_ERET * 10 + N_APB * 6;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    // Writable fields of Status and Cause
    localparam logic [31:0] STATUS_BITS = 32'h0040_ff03;
    localparam logic [31:0] CAUSE_BITS  = 32'h0080_0300;

    logic                clk;
    logic                reset;
    mips_pkg::stage_t    stallreq;
    mips_pkg::exc_req_t  exc_req;
    logic                eret;
    mips_pkg::addr_t     exc_pc;
    logic [5:0]          int_req;
    mips_pkg::stage_t    stall;
    mips_pkg::stage_t    flush;
    mips_pkg::addr_t     flush_pc;
    cp0_pkg::cp0_addr_t  paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    mips_pkg::data_t     pwdata;
    mips_pkg::data_t     prdata;
    logic                pready;
    logic                pslverr;

    mips_pkg::data_t     m_status;
    mips_pkg::data_t     m_cause;
    mips_pkg::data_t     m_epc;
    int                  n_pass;
    int                  n_fail;
    int                  fail_mark;
    int                  cycles;

    exc_unit_top #(
        .BOOT_BEV (BOOT_BEV)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .stallreq (stallreq),
        .exc_req  (exc_req),
        .eret     (eret),
        .exc_pc   (exc_pc),
        .int_req  (int_req),
        .stall    (stall),
        .flush    (flush),
        .flush_pc (flush_pc),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                $display("Simulation failed");
                $finish;
            end
        end
    end

    task automatic check_stage(input string what, input mips_pkg::stage_t got,
                               input mips_pkg::stage_t exp);
        if (got !== exp) begin
            n_fail++;
            $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_addr(input string what, input mips_pkg::addr_t got,
                              input mips_pkg::addr_t exp);
        if (got !== exp) begin
            n_fail++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_data(input string what, input mips_pkg::data_t got,
                              input mips_pkg::data_t exp);
        if (got !== exp) begin
            n_fail++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            n_fail++;
            $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
        end else begin
            n_pass++;
        end
    endtask

    // Cause code per request bit in priority order
    function automatic mips_pkg::exc_code_t code_of_req(input int idx);
        case (idx)
            0:       return mips_pkg::EXC_ADEL;
            1:       return mips_pkg::EXC_RI;
            2:       return mips_pkg::EXC_CPU;
            3:       return mips_pkg::EXC_OV;
            4:       return mips_pkg::EXC_TR;
            5:       return mips_pkg::EXC_SYS;
            6:       return mips_pkg::EXC_BP;
            7:       return mips_pkg::EXC_ADEL;
            default: return mips_pkg::EXC_ADES;
        endcase
    endfunction

    function automatic void predict_exc(output logic flag, output mips_pkg::exc_code_t code);
        logic [7:0] pend;
        int         i;
        // The decoder also sees the request pins directly
        pend = {m_cause[15:10] | int_req, m_cause[9:8]} & m_status[15:8];
        flag = 1'b1;
        code = mips_pkg::EXC_INT;
        if ((pend != 8'h00) && m_status[0] && !m_status[1]) begin
            return;
        end
        for (i = 0; i < 9; i++) begin
            if (exc_req[i]) begin
                code = code_of_req(i);
                return;
            end
        end
        if (eret) begin
            code = mips_pkg::EXC_ERET;
            return;
        end
        flag = 1'b0;
    endfunction

    function automatic void predict_pipe(input logic flag, input mips_pkg::exc_code_t code,
                                         output mips_pkg::stage_t e_stall,
                                         output mips_pkg::stage_t e_flush,
                                         output mips_pkg::addr_t e_pc);
        mips_pkg::addr_t base;
        base    = m_status[22] ? 32'hbfc0_0200 : 32'h8000_0000;
        e_stall = 5'b00000;
        e_flush = 5'b00000;
        e_pc    = 32'h0;
        if (flag) begin
            e_flush = 5'b11111;
            if (code == mips_pkg::EXC_INT) begin
                e_pc = base + (m_cause[23] ? 32'h200 : 32'h180);
            end else if (code == mips_pkg::EXC_ERET) begin
                e_pc = m_epc;
            end else begin
                e_pc = base + 32'h180;
            end
        end else if (stallreq == 5'b00010) begin
            e_stall = 5'b00011;
            e_flush = 5'b00100;
        end else if (stallreq[2] && !stallreq[4] && !stallreq[3] && !stallreq[0]) begin
            e_stall = 5'b00111;
            e_flush = 5'b01000;
        end else if (stallreq[0] && !stallreq[4] && !stallreq[3]) begin
            e_stall = 5'b01111;
            e_flush = 5'b10000;
        end else if (stallreq[3] && !stallreq[4]) begin
            e_stall = 5'b01111;
            e_flush = 5'b10000;
        end else if (stallreq[4]) begin
            e_stall = 5'b11111;
        end
    endfunction

    function automatic mips_pkg::data_t read_model(input cp0_pkg::cp0_addr_t addr);
        case (addr)
            4'h0:    return m_status;
            4'h4:    return m_cause;
            4'h8:    return m_epc;
            default: return 32'h0;
        endcase
    endfunction

    // State the registers hold after the coming rising edge
    function automatic void update_model(input logic flag, input mips_pkg::exc_code_t code);
        logic taken;
        logic wr;
        taken = flag && (code != mips_pkg::EXC_ERET);
        wr    = psel && penable && pwrite;
        if (taken) begin
            m_status[1]   = 1'b1;
            m_cause[6:2]  = code;
            m_epc         = exc_pc;
        end else begin
            if (flag) begin
                m_status[1] = 1'b0;  // ERET
            end else if (wr && (paddr == 4'h0)) begin
                m_status = (m_status & ~STATUS_BITS) | (pwdata & STATUS_BITS);
            end
            if (wr && (paddr == 4'h4)) begin
                m_cause = (m_cause & ~CAUSE_BITS) | (pwdata & CAUSE_BITS);
            end
            if (wr && (paddr == 4'h8)) begin
                m_epc = pwdata;
            end
        end
        m_cause[15:10] = int_req;
    endfunction

    // Checks one cycle and returns at the next rising edge
    task automatic tick;
        logic                flag;
        mips_pkg::exc_code_t code;
        mips_pkg::stage_t    e_stall;
        mips_pkg::stage_t    e_flush;
        mips_pkg::addr_t     e_pc;
        @(negedge clk);
        predict_exc(flag, code);
        predict_pipe(flag, code, e_stall, e_flush, e_pc);
        check_stage("stall", stall, e_stall);
        check_stage("flush", flush, e_flush);
        check_addr("flush_pc", flush_pc, e_pc);
        check_bit("pready", pready, 1'b1);
        check_bit("pslverr", pslverr, 1'b0);
        if (psel && penable && !pwrite) begin
            check_data("prdata", prdata, read_model(paddr));
        end
        update_model(flag, code);
        @(posedge clk);
    endtask

    task automatic apb_access(input cp0_pkg::cp0_addr_t addr, input logic wr,
                              input mips_pkg::data_t data);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= wr;
        psel    <= 1'b1;
        penable <= 1'b0;
        tick;
        penable <= 1'b1;
        tick;
        psel    <= 1'b0;  // Back to idle
        penable <= 1'b0;
        pwrite  <= 1'b0;
        tick;
    endtask

    task automatic report_test(input string name);
        $display("Test %s done, %0d errors", name, n_fail - fail_mark);
        fail_mark = n_fail;
    endtask

    initial begin
        logic [7:0]         im;
        bit                 bev;
        bit                 iv;
        mips_pkg::data_t    val;
        cp0_pkg::cp0_addr_t addr;

        void'($urandom(32'hb970_d4e9));
        n_pass = 0;
        n_fail = 0;
        fail_mark = 0;
        reset = 1'b1;
        stallreq = '0;
        exc_req = '0;
        eret = 1'b0;
        exc_pc = '0;
        int_req = '0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        m_status = 32'h0000_0002 | (32'(BOOT_BEV) << 22);  // EXL set out of reset
        m_cause  = 32'h0;
        m_epc    = 32'h0;

        apb_access(4'h0, 1'b0, 32'h0);
        apb_access(4'h4, 1'b0, 32'h0);
        apb_access(4'h8, 1'b0, 32'h0);
        apb_access(4'hc, 1'b0, 32'h0);
        int_req <= 6'($urandom_range(1, 63));
        tick;
        tick;
        int_req <= '0;
        tick;
        report_test("reset state");

        stallreq <= 5'b00101;  // EX and IF together
        tick;
        repeat (N_TABLE) begin
            stallreq <= 5'($urandom_range(0, 31));
            tick;
        end
        stallreq <= '0;
        report_test("stall table");

        for (int b = 0; b < 2; b++) begin
            apb_access(4'h0, 1'b1, 32'(b) << 22);
            repeat (N_SYNC) begin
                exc_req <= 9'($urandom_range(1, 511));
                exc_pc  <= $urandom;
                tick;
                exc_req <= '0;
                apb_access(4'h0, 1'b0, 32'h0);
                apb_access(4'h4, 1'b0, 32'h0);
                apb_access(4'h8, 1'b0, 32'h0);
            end
        end
        report_test("sync exceptions");

        for (int c = 0; c < 4; c++) begin
            bev = c[0];
            iv  = c[1];
            im  = 8'($urandom_range(0, 255));
            apb_access(4'h4, 1'b1, 32'(iv) << 23);
            repeat (N_INT) begin
                // IE on and EXL off
                apb_access(4'h0, 1'b1, (32'(bev) << 22) | (32'(im) << 8) | 32'h1);
                int_req <= 6'($urandom_range(0, 63));
                exc_req <= ($urandom_range(0, 1) == 1) ? 9'($urandom_range(1, 511)) : '0;
                exc_pc  <= $urandom;
                tick;
                int_req <= '0;
                exc_req <= '0;
                apb_access(4'h4, 1'b0, 32'h0);  // ExcCode shows which cause won
            end
        end
        report_test("interrupts");

        repeat (N_ERET) begin
            val = $urandom;
            apb_access(4'h0, 1'b1, (32'(BOOT_BEV) << 22) | 32'h2);
            apb_access(4'h8, 1'b1, val);
            eret <= 1'b1;
            tick;
            eret <= 1'b0;
            apb_access(4'h0, 1'b0, 32'h0);
        end
        report_test("eret");

        repeat (N_APB) begin
            case ($urandom_range(0, 3))
                0:       addr = 4'h0;
                1:       addr = 4'h4;
                2:       addr = 4'h8;
                default: addr = 4'hc;  // Unmapped
            endcase
            apb_access(addr, 1'b1, $urandom);
            apb_access(addr, 1'b0, 32'h0);
        end
        report_test("apb access");

        $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/exc_unit_sva.sv
//----------------------------------------
// Pipeline control assertions
// Checks stall, flush and redirect PC
// against the exception flag
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exc_unit_sva (
    input wire logic             clk,
    input wire logic             reset,
    input wire logic             exc_flag,
    input wire mips_pkg::stage_t stall,
    input wire mips_pkg::stage_t flush,
    input wire mips_pkg::addr_t  flush_pc
);

    // Exception discards the whole pipe
    a_exc_flush: assert property (@(posedge clk) disable iff (reset)
        exc_flag |-> (flush == 5'b11111) && (stall == 5'b00000))
        else $error("exception without full flush or with stall set");

    a_disjoint: assert property (@(posedge clk) disable iff (reset)
        !exc_flag |-> ((stall & flush) == 5'b00000))
        else $error("stall and flush overlap without exception");

    a_pc_idle: assert property (@(posedge clk) disable iff (reset)
        !exc_flag |-> (flush_pc == '0))
        else $error("flush_pc nonzero without exception");

endmodule

// pipe_control has no clock, so its outputs are watched from the top level
bind exc_unit_top exc_unit_sva u_sva (
    .clk      (clk),
    .reset    (reset),
    .exc_flag (exc_flag),
    .stall    (stall),
    .flush    (flush),
    .flush_pc (flush_pc)
);

`default_nettype wire

//--- rtl/exc_unit_top.sv
//----------------------------------------
// Exception unit top level
// Decoder, pipeline control and CP0 registers
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exc_unit_top #(
    parameter bit BOOT_BEV = 1'b1
) (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::stage_t   stallreq,
    input  mips_pkg::exc_req_t exc_req,
    input  logic               eret,
    input  mips_pkg::addr_t    exc_pc,
    input  logic [5:0]         int_req,
    output mips_pkg::stage_t   stall,
    output mips_pkg::stage_t   flush,
    output mips_pkg::addr_t    flush_pc,
    input  cp0_pkg::cp0_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  mips_pkg::data_t    pwdata,
    output mips_pkg::data_t    prdata,
    output logic               pready,
    output logic               pslverr
);

    mips_pkg::data_t     status;
    mips_pkg::data_t     cause;
    mips_pkg::data_t     epc;
    logic                exc_flag;
    mips_pkg::exc_code_t exc_type;

    exc_decode u_exc_decode (
        .int_req  (int_req),
        .exc_req  (exc_req),
        .eret     (eret),
        .status   (status),
        .cause    (cause),
        .exc_flag (exc_flag),
        .exc_type (exc_type)
    );

    pipe_control u_pipe_control (
        .stallreq (stallreq),
        .exc_flag (exc_flag),
        .exc_type (exc_type),
        .status   (status),
        .cause    (cause),
        .epc      (epc),
        .stall    (stall),
        .flush    (flush),
        .flush_pc (flush_pc)
    );

    cp0_regs #(
        .BOOT_BEV (BOOT_BEV)
    ) u_cp0_regs (
        .clk      (clk),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .int_req  (int_req),
        .exc_flag (exc_flag),
        .exc_type (exc_type),
        .exc_pc   (exc_pc),
        .status   (status),
        .cause    (cause),
        .epc      (epc)
    );

endmodule

`default_nettype wire

//--- rtl/cp0_regs.sv
//----------------------------------------
// Reduced CP0 register set
// Status, Cause and EPC behind an APB slave,
// updated on exception entry and ERET
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cp0_regs #(
    parameter bit BOOT_BEV = 1'b1
) (
    input  logic                clk,
    input  logic                reset,
    input  cp0_pkg::cp0_addr_t  paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  mips_pkg::data_t     pwdata,
    output mips_pkg::data_t     prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic [5:0]          int_req,
    input  logic                exc_flag,
    input  mips_pkg::exc_code_t exc_type,
    input  mips_pkg::addr_t     exc_pc,
    output mips_pkg::data_t     status,
    output mips_pkg::data_t     cause,
    output mips_pkg::data_t     epc
);

    logic apb_wr;
    logic exc_take;
    logic eret_take;

    // Writes land on the edge ending the access cycle
    assign apb_wr = psel && penable && pwrite;

    assign exc_take  = exc_flag && (exc_type != mips_pkg::EXC_ERET);
    assign eret_take = exc_flag && (exc_type == mips_pkg::EXC_ERET);

    // Status
    always_ff @(posedge clk) begin
        if (reset) begin
            status                      <= '0;
            status[cp0_pkg::STATUS_EXL] <= 1'b1;  // Interrupts held off at boot
            status[cp0_pkg::STATUS_BEV] <= BOOT_BEV;
        end else if (exc_take) begin
            status[cp0_pkg::STATUS_EXL] <= 1'b1;
        end else if (eret_take) begin
            status[cp0_pkg::STATUS_EXL] <= 1'b0;
        end else if (apb_wr && (paddr == cp0_pkg::CP0_STATUS)) begin
            status <= pwdata & cp0_pkg::STATUS_WMASK;
        end
    end

    // Cause
    always_ff @(posedge clk) begin
        if (reset) begin
            cause <= '0;
        end else begin
            if (exc_take) begin
                cause[cp0_pkg::CAUSE_EXC_HI:cp0_pkg::CAUSE_EXC_LO] <= exc_type;
            end else if (apb_wr && (paddr == cp0_pkg::CP0_CAUSE)) begin
                cause <= (cause & ~cp0_pkg::CAUSE_WMASK) | (pwdata & cp0_pkg::CAUSE_WMASK);
            end
            // Hardware IP bits follow the pins one cycle late
            cause[cp0_pkg::CAUSE_IP_HI:cp0_pkg::CAUSE_IP_HW_LO] <= int_req;
        end
    end

    // EPC, no delay-slot correction
    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (exc_take) begin
            epc <= exc_pc;
        end else if (apb_wr && (paddr == cp0_pkg::CP0_EPC)) begin
            epc <= pwdata;
        end
    end

    always_comb begin
        case (paddr)
            cp0_pkg::CP0_STATUS: prdata = status;
            cp0_pkg::CP0_CAUSE:  prdata = cause;
            cp0_pkg::CP0_EPC:    prdata = epc;
            default:             prdata = '0;  // Unmapped
        endcase
    end

    // Zero wait states, no error response
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

endmodule

`default_nettype wire

//--- rtl/pipe_control.sv
//----------------------------------------
// Pipeline stall and flush control
// Exception redirect overrides stall requests
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pipe_control (
    input  mips_pkg::stage_t    stallreq,
    input  logic                exc_flag,
    input  mips_pkg::exc_code_t exc_type,
    input  mips_pkg::data_t     status,
    input  mips_pkg::data_t     cause,
    input  mips_pkg::data_t     epc,
    output mips_pkg::stage_t    stall,
    output mips_pkg::stage_t    flush,
    output mips_pkg::addr_t     flush_pc
);

    logic            bev;
    logic            iv;
    mips_pkg::addr_t vec_base;
    mips_pkg::addr_t intr_ofs;

    assign bev = status[cp0_pkg::STATUS_BEV];
    assign iv  = cause[cp0_pkg::CAUSE_IV];

    // Boot vectors while BEV is set
    assign vec_base = bev ? cp0_pkg::VEC_BTS_BASE : cp0_pkg::VEC_NML_BASE;
    assign intr_ofs = iv ? cp0_pkg::OFS_INTR : cp0_pkg::OFS_GEN;

    always_comb begin
        stall    = 5'b00000;
        flush    = 5'b00000;
        flush_pc = '0;

        if (exc_flag) begin
            flush = 5'b11111;  // Whole pipe is discarded
            case (exc_type)
                mips_pkg::EXC_INT:  flush_pc = vec_base + intr_ofs;
                mips_pkg::EXC_ERET: flush_pc = epc;
                default:            flush_pc = vec_base + cp0_pkg::OFS_GEN;
            endcase
        end else begin
            // Order matters, first match wins
            casez (stallreq)
                5'b00010: begin  // ID
                    stall = 5'b00011;
                    flush = 5'b00100;
                end
                5'b001?0: begin  // EX
                    stall = 5'b00111;
                    flush = 5'b01000;
                end
                5'b00??1: begin  // IF, also wins over EX
                    stall = 5'b01111;
                    flush = 5'b10000;
                end
                5'b01???: begin  // MEM
                    stall = 5'b01111;
                    flush = 5'b10000;
                end
                5'b1????: begin
                    stall = 5'b11111;  // WB freezes everything
                    flush = 5'b00000;
                end
                default: begin
                    stall = 5'b00000;
                    flush = 5'b00000;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/exc_decode.sv
//----------------------------------------
// Exception decoder
// Ranks masked interrupts, MEM-stage requests
// and ERET into one flag and exception code
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exc_decode (
    input  logic [5:0]          int_req,
    input  mips_pkg::exc_req_t  exc_req,
    input  logic                eret,
    input  mips_pkg::data_t     status,
    input  mips_pkg::data_t     cause,
    output logic                exc_flag,
    output mips_pkg::exc_code_t exc_type
);

    logic [5:0] ip_hw;
    logic [7:0] ip_pend;
    logic       int_take;

    // Live request ORed in so a rising interrupt is seen without the Cause delay
    assign ip_hw = cause[cp0_pkg::CAUSE_IP_HI:cp0_pkg::CAUSE_IP_HW_LO] | int_req;

    assign ip_pend = {ip_hw, cause[cp0_pkg::CAUSE_IP_SW_HI:cp0_pkg::CAUSE_IP_LO]}
                   & status[cp0_pkg::STATUS_IM_HI:cp0_pkg::STATUS_IM_LO];

    assign int_take = (|ip_pend) && status[cp0_pkg::STATUS_IE]
                      && !status[cp0_pkg::STATUS_EXL];

    always_comb begin
        exc_flag = 1'b1;
        exc_type = mips_pkg::EXC_INT;
        if (int_take) begin
            exc_type = mips_pkg::EXC_INT;  // Interrupts outrank everything
        end else if (exc_req[mips_pkg::REQ_ADEL_IF]) begin
            exc_type = mips_pkg::EXC_ADEL;
        end else if (exc_req[mips_pkg::REQ_RI]) begin
            exc_type = mips_pkg::EXC_RI;
        end else if (exc_req[mips_pkg::REQ_CPU]) begin
            exc_type = mips_pkg::EXC_CPU;
        end else if (exc_req[mips_pkg::REQ_OV]) begin
            exc_type = mips_pkg::EXC_OV;
        end else if (exc_req[mips_pkg::REQ_TRAP]) begin
            exc_type = mips_pkg::EXC_TR;
        end else if (exc_req[mips_pkg::REQ_SYSC]) begin
            exc_type = mips_pkg::EXC_SYS;
        end else if (exc_req[mips_pkg::REQ_BP]) begin
            exc_type = mips_pkg::EXC_BP;
        end else if (exc_req[mips_pkg::REQ_ADEL_LD]) begin
            exc_type = mips_pkg::EXC_ADEL;
        end else if (exc_req[mips_pkg::REQ_ADES]) begin
            exc_type = mips_pkg::EXC_ADES;
        end else if (eret) begin
            exc_type = mips_pkg::EXC_ERET;
        end else begin
            exc_flag = 1'b0;  // Code is don't-care here
        end
    end

endmodule

`default_nettype wire

//--- rtl/cp0_pkg.sv
//----------------------------------------
// CP0 package
// Register map, Status and Cause field positions,
// exception vector bases and offsets
//----------------------------------------
`default_nettype none

package cp0_pkg;

    typedef logic [3:0] cp0_addr_t;

    // APB register map, other addresses read zero
    localparam cp0_addr_t CP0_STATUS = 4'h0;
    localparam cp0_addr_t CP0_CAUSE  = 4'h4;
    localparam cp0_addr_t CP0_EPC    = 4'h8;

    // Status fields
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 8;
    localparam int STATUS_IM_HI = 15;
    localparam int STATUS_BEV   = 22;

    // Cause fields
    localparam int CAUSE_EXC_LO   = 2;
    localparam int CAUSE_EXC_HI   = 6;
    localparam int CAUSE_IP_LO    = 8;
    localparam int CAUSE_IP_SW_HI = 9;   // IP[1:0] are software interrupts
    localparam int CAUSE_IP_HW_LO = 10;
    localparam int CAUSE_IP_HI    = 15;
    localparam int CAUSE_IV       = 23;

    // Host writable bits
    localparam logic [31:0] STATUS_WMASK = 32'h0040_ff03;
    localparam logic [31:0] CAUSE_WMASK  = 32'h0080_0300;

    // Exception vectors
    localparam logic [31:0] VEC_NML_BASE = 32'h8000_0000;
    localparam logic [31:0] VEC_BTS_BASE = 32'hbfc0_0200;
    localparam logic [31:0] OFS_GEN      = 32'h0000_0180;
    localparam logic [31:0] OFS_INTR     = 32'h0000_0200;

endpackage

`default_nettype wire

//--- rtl/mips_pkg.sv
//----------------------------------------
// MIPS32 pipeline package
// Stage, data, address and exception code types
// Request mask bit indices, lowest is highest priority
//----------------------------------------
`default_nettype none

package mips_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;

    // One bit per stage: 0 IF, 1 ID, 2 EX, 3 MEM, 4 WB
    typedef logic [4:0] stage_t;

    // Cause.ExcCode encoding
    typedef logic [4:0] exc_code_t;

    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_SYS  = 5'd8;
    localparam exc_code_t EXC_BP   = 5'd9;
    localparam exc_code_t EXC_RI   = 5'd10;
    localparam exc_code_t EXC_CPU  = 5'd11;
    localparam exc_code_t EXC_OV   = 5'd12;
    localparam exc_code_t EXC_TR   = 5'd13;
    localparam exc_code_t EXC_ERET = 5'd31;  // Internal only, never written to Cause

    // Synchronous requests raised by the MEM stage
    localparam int N_REQ = 9;

    typedef logic [N_REQ-1:0] exc_req_t;

    localparam int REQ_ADEL_IF = 0;  // Instruction fetch address error
    localparam int REQ_RI      = 1;
    localparam int REQ_CPU     = 2;
    localparam int REQ_OV      = 3;
    localparam int REQ_TRAP    = 4;
    localparam int REQ_SYSC    = 5;
    localparam int REQ_BP      = 6;
    localparam int REQ_ADEL_LD = 7;  // Load address error
    localparam int REQ_ADES    = 8;

endpackage

`default_nettype wire
